// File: rtl/udp_rx_pkg.sv
/*
 * UDP receive stage shared definitions
 * field types, header byte count, FSM encoding and the payload beat
 */
package udp_rx_pkg;

    // stream and field types
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] port_t;
    typedef logic [15:0] len_t;
    typedef logic [15:0] csum_t;
    typedef logic [31:0] ip_addr_t;

    // frame byte pointer, compared against the UDP length
    typedef logic [15:0] ptr_t;

    // source port, dest port, length and checksum, two bytes each
    localparam ptr_t UDP_HDR_BYTES = 16'd8;

    // frame FSM states
    typedef enum logic [1:0] {
        idle,
        read_header,
        read_payload,
        read_payload_last
    } rx_state_t;

    // one payload stream beat
    typedef struct packed {
        byte_t data;
        logic  last;
        logic  user;
    } udp_beat_t;

endpackage

// File: rtl/udp_hdr_regs.sv
`timescale 1ns/1ps

/*
 * UDP header registers
 * latches the IP addresses and assembles the four UDP fields from the stream
 */
module udp_hdr_regs
    import udp_rx_pkg::*;
(
    input  logic       clk,

    input  logic       store_ip_hdr,
    input  ip_addr_t   ip_source_ip,
    input  ip_addr_t   ip_dest_ip,

    input  logic       hdr_byte_en,
    input  logic [2:0] hdr_byte_sel,
    input  byte_t      ip_payload_tdata,

    output ip_addr_t   udp_ip_source_ip,
    output ip_addr_t   udp_ip_dest_ip,
    output port_t      udp_source_port,
    output port_t      udp_dest_port,
    output len_t       udp_length,
    output csum_t      udp_checksum
);

    // IP addresses taken with the input header
    always_ff @(posedge clk) begin
        if (store_ip_hdr) begin
            udp_ip_source_ip <= ip_source_ip;
            udp_ip_dest_ip <= ip_dest_ip;
        end
    end

    // network byte order, high byte arrives first
    always_ff @(posedge clk) begin
        if (hdr_byte_en) begin
            case (hdr_byte_sel)
                3'd0: udp_source_port[15:8] <= ip_payload_tdata;
                3'd1: udp_source_port[7:0] <= ip_payload_tdata;
                3'd2: udp_dest_port[15:8] <= ip_payload_tdata;
                3'd3: udp_dest_port[7:0] <= ip_payload_tdata;
                3'd4: udp_length[15:8] <= ip_payload_tdata;
                3'd5: udp_length[7:0] <= ip_payload_tdata;
                3'd6: udp_checksum[15:8] <= ip_payload_tdata;
                3'd7: udp_checksum[7:0] <= ip_payload_tdata;
                default: ;
            endcase
        end
    end

endmodule

// File: rtl/udp_skid_buffer.sv
`timescale 1ns/1ps

/*
 * Payload skid buffer
 * output register plus one spare entry so upstream ready can be registered
 */
module udp_skid_buffer
    import udp_rx_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    input  udp_beat_t in_beat,
    input  logic      in_valid,
    output logic      ready_early,

    output udp_beat_t out_beat,
    output logic      out_valid,
    input  logic      out_ready
);

    udp_beat_t out_beat_reg;
    logic      out_valid_reg, out_valid_next;

    udp_beat_t temp_beat_reg;
    logic      temp_valid_reg, temp_valid_next;

    // registered copy of ready_early that matches upstream ready
    logic ready_reg;

    logic store_in_to_out;
    logic store_in_to_temp;
    logic store_temp_to_out;

    // ready next cycle unless the spare entry could fill up
    assign ready_early = out_ready || (!temp_valid_reg && (!out_valid_reg || !in_valid));

    always_comb begin
        out_valid_next = out_valid_reg;
        temp_valid_next = temp_valid_reg;

        store_in_to_out = 1'b0;
        store_in_to_temp = 1'b0;
        store_temp_to_out = 1'b0;

        if (ready_reg) begin
            if (out_ready || !out_valid_reg) begin
                out_valid_next = in_valid;
                store_in_to_out = 1'b1;
            end else begin
                // stalled output parks the beat in the spare entry
                temp_valid_next = in_valid;
                store_in_to_temp = 1'b1;
            end
        end else if (out_ready) begin
            out_valid_next = temp_valid_reg;
            temp_valid_next = 1'b0;
            store_temp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid_reg <= 1'b0;
            temp_valid_reg <= 1'b0;
            ready_reg <= 1'b0;
        end else begin
            out_valid_reg <= out_valid_next;
            temp_valid_reg <= temp_valid_next;
            ready_reg <= ready_early;
        end

        if (store_in_to_out) begin
            out_beat_reg <= in_beat;
        end else if (store_temp_to_out) begin
            out_beat_reg <= temp_beat_reg;
        end

        if (store_in_to_temp) begin
            temp_beat_reg <= in_beat;
        end
    end

    assign out_beat = out_beat_reg;
    assign out_valid = out_valid_reg;

    // stalled output holds its beat
    out_stable: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> $stable(out_beat) && out_valid);

    // spare entry is never overwritten
    temp_no_overwrite: assert property (@(posedge clk) disable iff (rst)
        store_in_to_temp |-> !temp_valid_reg);

endmodule

// File: rtl/udp_rx_fsm.sv
`timescale 1ns/1ps

/*
 * UDP receive frame FSM
 * walks the header and payload bytes, counts them against the UDP length,
 * trims excess bytes and flags early termination
 */
module udp_rx_fsm
    import udp_rx_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    input  logic       ip_hdr_valid,
    output logic       ip_hdr_ready,
    input  byte_t      ip_payload_tdata,
    input  logic       ip_payload_tvalid,
    output logic       ip_payload_tready,
    input  logic       ip_payload_tlast,
    input  logic       ip_payload_tuser,

    output logic       udp_hdr_valid,
    input  logic       udp_hdr_ready,
    input  len_t       udp_length,

    output logic       store_ip_hdr,
    output logic       hdr_byte_en,
    output logic [2:0] hdr_byte_sel,

    output udp_beat_t  beat,
    output logic       beat_valid,
    input  logic       ready_early,

    output logic       busy,
    output logic       error_header_early_termination,
    output logic       error_payload_early_termination
);

    rx_state_t state_reg, state_next;

    ptr_t  frame_ptr_reg, frame_ptr_next;
    ptr_t  frame_ptr_inc;

    // final byte of a trimmed frame held until input last
    byte_t last_byte_reg;
    logic  store_last_byte;

    logic hdr_ready_reg, hdr_ready_next;
    logic tready_reg, tready_next;
    logic hdr_valid_reg, hdr_valid_next;
    logic busy_reg;
    logic err_hdr_reg, err_hdr_next;
    logic err_pay_reg, err_pay_next;

    logic in_xfer;

    assign in_xfer = ip_payload_tready && ip_payload_tvalid;
    assign frame_ptr_inc = frame_ptr_reg + 16'd1;

    // header bytes land in the field selected by the low pointer bits
    assign hdr_byte_sel = frame_ptr_reg[2:0];

    always_comb begin
        state_next = state_reg;
        frame_ptr_next = frame_ptr_reg;

        hdr_ready_next = 1'b0;
        tready_next = 1'b0;

        store_ip_hdr = 1'b0;
        hdr_byte_en = 1'b0;
        store_last_byte = 1'b0;

        // header output stays up until downstream takes it
        hdr_valid_next = hdr_valid_reg && !udp_hdr_ready;

        err_hdr_next = 1'b0;
        err_pay_next = 1'b0;

        beat = '0;
        beat_valid = 1'b0;

        case (state_reg)
            idle: begin
                frame_ptr_next = '0;
                hdr_ready_next = !hdr_valid_next;

                if (ip_hdr_ready && ip_hdr_valid) begin
                    hdr_ready_next = 1'b0;
                    tready_next = 1'b1;
                    store_ip_hdr = 1'b1;
                    state_next = read_header;
                end
            end
            read_header: begin
                tready_next = 1'b1;

                if (in_xfer) begin
                    frame_ptr_next = frame_ptr_inc;
                    hdr_byte_en = 1'b1;

                    if (frame_ptr_inc == UDP_HDR_BYTES) begin
                        hdr_valid_next = 1'b1;
                        tready_next = ready_early;
                        state_next = read_payload;
                    end

                    // frame ended inside the UDP header and is dropped
                    if (ip_payload_tlast) begin
                        err_hdr_next = 1'b1;
                        hdr_valid_next = 1'b0;
                        hdr_ready_next = 1'b1;
                        tready_next = 1'b0;
                        state_next = idle;
                    end
                end
            end
            read_payload: begin
                tready_next = ready_early;

                beat.data = ip_payload_tdata;
                beat.last = ip_payload_tlast;
                beat.user = ip_payload_tuser;
                beat_valid = ip_payload_tvalid;

                if (in_xfer) begin
                    frame_ptr_next = frame_ptr_inc;
                    if (ip_payload_tlast) begin
                        // short frame marks its final beat bad
                        if (frame_ptr_inc != udp_length) begin
                            beat.user = 1'b1;
                            err_pay_next = 1'b1;
                        end
                        hdr_ready_next = !hdr_valid_next;
                        tready_next = 1'b0;
                        state_next = idle;
                    end else if (frame_ptr_inc == udp_length) begin
                        // length reached so this byte waits for input last
                        store_last_byte = 1'b1;
                        beat_valid = 1'b0;
                        state_next = read_payload_last;
                    end
                end
            end
            read_payload_last: begin
                tready_next = ready_early;

                beat.data = last_byte_reg;
                beat.last = ip_payload_tlast;
                beat.user = ip_payload_tuser;
                beat_valid = ip_payload_tvalid && ip_payload_tlast;

                // excess bytes are consumed and dropped
                if (in_xfer && ip_payload_tlast) begin
                    hdr_ready_next = !hdr_valid_next;
                    tready_next = 1'b0;
                    state_next = idle;
                end
            end
            default: begin
                state_next = idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg <= idle;
            frame_ptr_reg <= '0;
            hdr_ready_reg <= 1'b0;
            tready_reg <= 1'b0;
            hdr_valid_reg <= 1'b0;
            busy_reg <= 1'b0;
            err_hdr_reg <= 1'b0;
            err_pay_reg <= 1'b0;
        end else begin
            state_reg <= state_next;
            frame_ptr_reg <= frame_ptr_next;
            hdr_ready_reg <= hdr_ready_next;
            tready_reg <= tready_next;
            hdr_valid_reg <= hdr_valid_next;
            busy_reg <= state_next != idle;
            err_hdr_reg <= err_hdr_next;
            err_pay_reg <= err_pay_next;
        end

        if (store_last_byte) begin
            last_byte_reg <= ip_payload_tdata;
        end
    end

    assign ip_hdr_ready = hdr_ready_reg;
    assign ip_payload_tready = tready_reg;
    assign udp_hdr_valid = hdr_valid_reg;
    assign busy = busy_reg;
    assign error_header_early_termination = err_hdr_reg;
    assign error_payload_early_termination = err_pay_reg;

    // header output only drops after a downstream transfer
    hdr_valid_hold: assert property (@(posedge clk) disable iff (rst)
        udp_hdr_valid && !udp_hdr_ready |=> udp_hdr_valid);

    // no stream byte is taken between frames
    no_byte_in_idle: assert property (@(posedge clk) disable iff (rst)
        state_reg == idle |-> !ip_payload_tready);

endmodule

// File: rtl/udp_ip_rx.sv
`timescale 1ns/1ps

/*
 * UDP receive stage top level
 * IP frame in, UDP header in parallel and trimmed UDP payload stream out
 */
module udp_ip_rx
    import udp_rx_pkg::*;
(
    input  logic     clk,
    input  logic     rst,

    // IP frame input
    input  logic     ip_hdr_valid,
    output logic     ip_hdr_ready,
    input  ip_addr_t ip_source_ip,
    input  ip_addr_t ip_dest_ip,
    input  byte_t    ip_payload_tdata,
    input  logic     ip_payload_tvalid,
    output logic     ip_payload_tready,
    input  logic     ip_payload_tlast,
    input  logic     ip_payload_tuser,

    // UDP frame output
    output logic     udp_hdr_valid,
    input  logic     udp_hdr_ready,
    output ip_addr_t udp_ip_source_ip,
    output ip_addr_t udp_ip_dest_ip,
    output port_t    udp_source_port,
    output port_t    udp_dest_port,
    output len_t     udp_length,
    output csum_t    udp_checksum,
    output byte_t    udp_payload_tdata,
    output logic     udp_payload_tvalid,
    input  logic     udp_payload_tready,
    output logic     udp_payload_tlast,
    output logic     udp_payload_tuser,

    // status
    output logic     busy,
    output logic     error_header_early_termination,
    output logic     error_payload_early_termination
);

    logic       store_ip_hdr;
    logic       hdr_byte_en;
    logic [2:0] hdr_byte_sel;

    udp_beat_t  beat;
    logic       beat_valid;
    logic       ready_early;
    udp_beat_t  out_beat;

    udp_rx_fsm fsm0 (
        .clk                             (clk),
        .rst                             (rst),
        .ip_hdr_valid                    (ip_hdr_valid),
        .ip_hdr_ready                    (ip_hdr_ready),
        .ip_payload_tdata                (ip_payload_tdata),
        .ip_payload_tvalid               (ip_payload_tvalid),
        .ip_payload_tready               (ip_payload_tready),
        .ip_payload_tlast                (ip_payload_tlast),
        .ip_payload_tuser                (ip_payload_tuser),
        .udp_hdr_valid                   (udp_hdr_valid),
        .udp_hdr_ready                   (udp_hdr_ready),
        .udp_length                      (udp_length),
        .store_ip_hdr                    (store_ip_hdr),
        .hdr_byte_en                     (hdr_byte_en),
        .hdr_byte_sel                    (hdr_byte_sel),
        .beat                            (beat),
        .beat_valid                      (beat_valid),
        .ready_early                     (ready_early),
        .busy                            (busy),
        .error_header_early_termination  (error_header_early_termination),
        .error_payload_early_termination (error_payload_early_termination)
    );

    udp_hdr_regs hdr0 (
        .clk              (clk),
        .store_ip_hdr     (store_ip_hdr),
        .ip_source_ip     (ip_source_ip),
        .ip_dest_ip       (ip_dest_ip),
        .hdr_byte_en      (hdr_byte_en),
        .hdr_byte_sel     (hdr_byte_sel),
        .ip_payload_tdata (ip_payload_tdata),
        .udp_ip_source_ip (udp_ip_source_ip),
        .udp_ip_dest_ip   (udp_ip_dest_ip),
        .udp_source_port  (udp_source_port),
        .udp_dest_port    (udp_dest_port),
        .udp_length       (udp_length),
        .udp_checksum     (udp_checksum)
    );

    udp_skid_buffer skid0 (
        .clk         (clk),
        .rst         (rst),
        .in_beat     (beat),
        .in_valid    (beat_valid),
        .ready_early (ready_early),
        .out_beat    (out_beat),
        .out_valid   (udp_payload_tvalid),
        .out_ready   (udp_payload_tready)
    );

    // unpack the output beat onto the stream ports
    assign udp_payload_tdata = out_beat.data;
    assign udp_payload_tlast = out_beat.last;
    assign udp_payload_tuser = out_beat.user;

endmodule

// File: verif/tb_udp_frames.svh
/*
 * UDP receive stage stimulus table
 * one row per frame with header values, bytes sent and back-pressure flag
 */
`ifndef TB_UDP_FRAMES_SVH
`define TB_UDP_FRAMES_SVH

typedef logic [71:0] test_name_t;

// sent counts every stream byte, the UDP header included
typedef struct packed {
    test_name_t name;
    ip_addr_t   src_ip;
    ip_addr_t   dst_ip;
    port_t      src_port;
    port_t      dst_port;
    len_t       length;
    csum_t      checksum;
    len_t       sent;
    logic       bp;
} frame_row_t;

localparam int NUM_FRAMES = 9;
localparam int MAX_SENT = 64;

// name, source ip, dest ip, source port, dest port,
// then udp length, checksum, bytes sent, back-pressure
localparam frame_row_t FRAMES [NUM_FRAMES] = '{
    '{"exact_len", 32'hc0a80001, 32'hc0a80002, 16'h1388, 16'h0035,
      16'd20, 16'h1a2b, 16'd20, 1'b0},
    '{"long_trim", 32'h0a000001, 32'h0a000002, 16'h0044, 16'h0043,
      16'd16, 16'h0000, 16'd24, 1'b0},
    '{"short_end", 32'hac100005, 32'hac100009, 16'hd431, 16'h01bb,
      16'd30, 16'h7e91, 16'd18, 1'b0},
    '{"hdr_early", 32'hc0a80a01, 32'hc0a80a02, 16'h1f90, 16'h1f91,
      16'd20, 16'h5555, 16'd5, 1'b0},
    '{"after_hdr", 32'hc0a80a03, 32'hc0a80a04, 16'h2710, 16'h2711,
      16'd12, 16'h3c3c, 16'd12, 1'b0},
    '{"bp_equals", 32'h08080808, 32'h08080404, 16'h0035, 16'he123,
      16'd40, 16'hbeef, 16'd40, 1'b1},
    '{"bp_longer", 32'h7f000001, 32'h7f000001, 16'h0bb8, 16'h0bb9,
      16'd25, 16'hc0de, 16'd33, 1'b1},
    '{"bp_cutoff", 32'hac1f0001, 32'hac1f00fe, 16'h3039, 16'h303a,
      16'd50, 16'h0f0f, 16'd30, 1'b1},
    '{"min_len_9", 32'he0000001, 32'he00000fb, 16'h14e9, 16'h14e9,
      16'd9, 16'h9a9a, 16'd9, 1'b0}
};

`endif

// File: verif/tb_udp_ip_rx.sv
`timescale 1ns/1ps

/*
 * UDP receive stage testbench
 * drives the frame table through the DUT, checks header, payload and error pulses
 */
module tb_udp_ip_rx
    import udp_rx_pkg::*;
();

    `include "tb_udp_frames.svh"

    localparam int HALF_PERIOD = 50;
    localparam int DRIVE_DELAY = 1;
    localparam int IDLE_GAP = 4;
    localparam int HDR_BYTES = int'(UDP_HDR_BYTES);

    typedef struct packed {
        ip_addr_t src_ip;
        ip_addr_t dst_ip;
        port_t    src_port;
        port_t    dst_port;
        len_t     length;
        csum_t    checksum;
    } hdr_fields_t;

    logic     clk = 1'b0;
    logic     rst;
    logic     ip_hdr_valid, ip_hdr_ready;
    ip_addr_t ip_source_ip, ip_dest_ip;
    byte_t    ip_payload_tdata;
    logic     ip_payload_tvalid, ip_payload_tready, ip_payload_tlast, ip_payload_tuser;
    logic     udp_hdr_valid, udp_hdr_ready;
    ip_addr_t udp_ip_source_ip, udp_ip_dest_ip;
    port_t    udp_source_port, udp_dest_port;
    len_t     udp_length;
    csum_t    udp_checksum;
    byte_t    udp_payload_tdata;
    logic     udp_payload_tvalid, udp_payload_tready, udp_payload_tlast, udp_payload_tuser;
    logic     busy, error_header_early_termination, error_payload_early_termination;

    integer      seed = 32'ha1c9_a6bb;
    byte_t       frame_data [NUM_FRAMES][MAX_SENT];
    hdr_fields_t exp_hdrs [$];
    int          hdr_rows [$];
    udp_beat_t   exp_beats [$];
    int          beat_rows [$];
    hdr_fields_t act_hdr;
    udp_beat_t   act_beat;
    logic        cur_bp;
    int          hdr_errs;
    int          pay_errs;
    int          cycles = 0;
    int          cycle_limit;

    udp_ip_rx dut0 (.*);

    always #HALF_PERIOD clk = ~clk;

    assign act_hdr = {udp_ip_source_ip, udp_ip_dest_ip, udp_source_port, udp_dest_port,
                      udp_length, udp_checksum};
    assign act_beat = {udp_payload_tdata, udp_payload_tlast, udp_payload_tuser};

    task automatic stop_with_error(input string line);
        $display("%s", line);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_header(input test_name_t name, input hdr_fields_t exp,
                                input hdr_fields_t act);
        if (exp !== act) begin
            stop_with_error($sformatf("Mismatch: test %0s header expected %h actual %h",
                                      name, exp, act));
        end
    endtask

    task automatic check_beat(input test_name_t name, input udp_beat_t exp,
                              input udp_beat_t act);
        if (exp !== act) begin
            stop_with_error($sformatf(
                "Mismatch: test %0s beat expected data %h last %b user %b actual %h %b %b",
                name, exp.data, exp.last, exp.user, act.data, act.last, act.user));
        end
    endtask

    task automatic check_count(input test_name_t name, input string what,
                               input int exp, input int act);
        if (exp != act) begin
            stop_with_error($sformatf("Mismatch: test %0s %0s expected %0d actual %0d",
                                      name, what, exp, act));
        end
    endtask

    task automatic check_level(input test_name_t name, input string what,
                               input logic exp, input logic act);
        if (exp !== act) begin
            stop_with_error($sformatf("Mismatch: test %0s %0s expected %b actual %b",
                                      name, what, exp, act));
        end
    endtask

    // header bytes from the row, payload bytes random, all drawn before the clock starts
    task automatic build_stream_bytes();
        frame_row_t row;
        integer     rnd;
        int         total;
        total = 0;
        for (int r = 0; r < NUM_FRAMES; r++) begin
            row = FRAMES[r];
            {frame_data[r][0], frame_data[r][1]} = row.src_port;
            {frame_data[r][2], frame_data[r][3]} = row.dst_port;
            {frame_data[r][4], frame_data[r][5]} = row.length;
            {frame_data[r][6], frame_data[r][7]} = row.checksum;
            for (int i = HDR_BYTES; i < MAX_SENT; i++) begin
                rnd = $random(seed);
                frame_data[r][i] = rnd[7:0];
            end
            total += int'(row.sent);
        end
        cycle_limit = 10 * total + 200;
    endtask

    task automatic push_expected(input int r);
        frame_row_t  row;
        hdr_fields_t hdr;
        udp_beat_t   b;
        int          sent;
        int          length;
        int          n;
        row = FRAMES[r];
        sent = int'(row.sent);
        length = int'(row.length);
        // a frame cut inside the UDP header produces nothing
        if (sent > HDR_BYTES) begin
            hdr = {row.src_ip, row.dst_ip, row.src_port, row.dst_port, row.length,
                   row.checksum};
            exp_hdrs.push_back(hdr);
            hdr_rows.push_back(r);
            n = (sent < length ? sent : length) - HDR_BYTES;
            for (int k = 0; k < n; k++) begin
                b.data = frame_data[r][HDR_BYTES + k];
                b.last = (k == n - 1);
                b.user = (k == n - 1) && (sent < length);
                exp_beats.push_back(b);
                beat_rows.push_back(r);
            end
        end
    endtask

    task automatic take_header();
        int r;
        if (exp_hdrs.size() == 0) begin
            stop_with_error("A UDP header came out while no header was expected");
        end else begin
            r = hdr_rows.pop_front();
            check_header(FRAMES[r].name, exp_hdrs.pop_front(), act_hdr);
        end
    endtask

    task automatic take_beat();
        int r;
        if (exp_beats.size() == 0) begin
            stop_with_error("A payload beat came out while no byte was expected");
        end else begin
            r = beat_rows.pop_front();
            check_beat(FRAMES[r].name, exp_beats.pop_front(), act_beat);
        end
    endtask

    task automatic send_frame(input int r);
        test_name_t name;
        int         sent;
        int         length;
        name = FRAMES[r].name;
        sent = int'(FRAMES[r].sent);
        length = int'(FRAMES[r].length);
        @(negedge clk);
        cur_bp = FRAMES[r].bp;
        @(posedge clk);
        #DRIVE_DELAY;
        hdr_errs = 0;
        pay_errs = 0;
        push_expected(r);
        ip_hdr_valid = 1'b1;
        ip_source_ip = FRAMES[r].src_ip;
        ip_dest_ip = FRAMES[r].dst_ip;
        do begin
            @(negedge clk);
        end while (!ip_hdr_ready);
        @(posedge clk);
        #DRIVE_DELAY;
        ip_hdr_valid = 1'b0;
        for (int i = 0; i < sent; i++) begin
            ip_payload_tdata = frame_data[r][i];
            ip_payload_tvalid = 1'b1;
            ip_payload_tlast = (i == sent - 1);
            do begin
                @(negedge clk);
            end while (!ip_payload_tready);
            check_level(name, "busy during frame", 1'b1, busy);
            @(posedge clk);
            #DRIVE_DELAY;
        end
        ip_payload_tvalid = 1'b0;
        ip_payload_tlast = 1'b0;
        repeat (IDLE_GAP) @(posedge clk);
        #DRIVE_DELAY;
        check_level(name, "busy after frame", 1'b0, busy);
        check_count(name, "header error pulses", sent <= HDR_BYTES ? 1 : 0, hdr_errs);
        check_count(name, "payload error pulses",
                    (sent > HDR_BYTES && sent < length) ? 1 : 0, pay_errs);
    endtask

    // output readies, random only for back-pressure rows
    always @(posedge clk) begin
        #DRIVE_DELAY;
        if (cur_bp) begin
            udp_hdr_ready = ($random(seed) & 1) != 0;
            udp_payload_tready = ($random(seed) & 3) != 0;
        end else begin
            udp_hdr_ready = 1'b1;
            udp_payload_tready = 1'b1;
        end
    end

    // outputs are stable mid cycle
    always @(negedge clk) begin
        if (!rst) begin
            if (udp_hdr_valid && udp_hdr_ready) begin
                take_header();
            end
            if (udp_payload_tvalid && udp_payload_tready) begin
                take_beat();
            end
            if (error_header_early_termination) begin
                hdr_errs++;
            end
            if (error_payload_early_termination) begin
                pay_errs++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            stop_with_error($sformatf("Timeout: frames still pending after %0d cycles",
                                      cycle_limit));
        end
    end

    initial begin
        rst = 1'b1;
        cur_bp = 1'b0;
        ip_hdr_valid = 1'b0;
        ip_source_ip = '0;
        ip_dest_ip = '0;
        ip_payload_tdata = '0;
        ip_payload_tvalid = 1'b0;
        ip_payload_tlast = 1'b0;
        ip_payload_tuser = 1'b0;
        udp_hdr_ready = 1'b1;
        udp_payload_tready = 1'b1;
        hdr_errs = 0;
        pay_errs = 0;
        build_stream_bytes();

        repeat (2) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
        check_level("reset_lvl", "ip_hdr_ready", 1'b0, ip_hdr_ready);
        check_level("reset_lvl", "ip_payload_tready", 1'b0, ip_payload_tready);
        check_level("reset_lvl", "udp_hdr_valid", 1'b0, udp_hdr_valid);
        check_level("reset_lvl", "udp_payload_tvalid", 1'b0, udp_payload_tvalid);
        check_level("reset_lvl", "busy", 1'b0, busy);
        check_level("reset_lvl", "header error", 1'b0, error_header_early_termination);
        check_level("reset_lvl", "payload error", 1'b0, error_payload_early_termination);
        @(posedge clk);
        #DRIVE_DELAY;
        check_level("reset_lvl", "ip_hdr_ready after release", 1'b1, ip_hdr_ready);

        for (int r = 0; r < NUM_FRAMES; r++) begin
            send_frame(r);
        end

        // let the skid buffer and header output drain
        while (exp_hdrs.size() != 0 || exp_beats.size() != 0) begin
            @(posedge clk);
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: udp_ip_rx.f
+incdir+verif
rtl/udp_rx_pkg.sv
rtl/udp_hdr_regs.sv
rtl/udp_skid_buffer.sv
rtl/udp_rx_fsm.sv
rtl/udp_ip_rx.sv
verif/tb_udp_ip_rx.sv

// File: run_sim.sh
#!/bin/sh
# build the UDP receive testbench with Verilator and run it
# exit status is nonzero when the build fails or the run ends in $fatal
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 \
    --top-module tb_udp_ip_rx \
    -f udp_ip_rx.f \
    -o tb_udp_ip_rx &&
./obj_dir/tb_udp_ip_rx ||
{ echo "build or simulation returned an error status"; exit 1; }
